// ==== verilog/router_pkg.sv ====
//----------------------------------------
// shared widths, message layout and types for the ring router
// import into a module body, use scoped names in port lists
//----------------------------------------

package router_pkg;

  //----------------------------------------
  // widths and sizes
  //----------------------------------------

  localparam int PAYLOAD_NBITS = 32;
  localparam int OPAQUE_NBITS  = 3;
  localparam int SRCDEST_NBITS = 3;
  // dest | src | opaque | payload, from the top
  localparam int NET_MSG_NBITS = 2 * SRCDEST_NBITS + OPAQUE_NBITS + PAYLOAD_NBITS;

  localparam int NUM_ROUTERS = 8;
  localparam int NUM_PORTS   = 3;
  localparam int QUEUE_DEPTH = 4;

  //----------------------------------------
  // types
  //----------------------------------------

  typedef logic [NET_MSG_NBITS-1:0] net_msg_t;
  typedef logic [SRCDEST_NBITS-1:0] node_id_t;
  typedef logic [PAYLOAD_NBITS-1:0] payload_t;
  typedef logic [OPAQUE_NBITS-1:0]  opaque_t;

  // one-hot output set, bit 0 west, bit 1 terminal, bit 2 east
  typedef logic [NUM_PORTS-1:0] port_mask_t;
  typedef logic [1:0]           port_sel_t;

  typedef enum logic [1:0] {
    PORT_WEST = 2'd0,
    PORT_TERM = 2'd1,
    PORT_EAST = 2'd2
  } port_e;

  // field extraction
  function automatic node_id_t msg_dest(input net_msg_t msg);
    return msg[NET_MSG_NBITS-1 -: SRCDEST_NBITS];
  endfunction

  function automatic payload_t msg_payload(input net_msg_t msg);
    return msg[PAYLOAD_NBITS-1:0];
  endfunction

endpackage

// ==== verilog/switch_chan_if.sv ====
//----------------------------------------
// request and grant channel from one input port to the allocator
//----------------------------------------

interface switch_chan_if;
  import router_pkg::*;

  // head of the input queue, as offered to the switch
  logic       val;
  net_msg_t   msg;
  port_mask_t reqs;

  // head leaves on the next edge
  logic       grant;

  modport input_side (
    output val, msg, reqs,
    input  grant
  );

  modport alloc_side (
    input  val, msg, reqs,
    output grant
  );

endinterface

// ==== verilog/net_queue.sv ====
//----------------------------------------
// small val/rdy message queue, one cycle from enqueue to head
//----------------------------------------

module net_queue (
  input  logic                 clk,
  input  logic                 reset,

  input  logic                 enq_val,
  output logic                 enq_rdy,
  input  router_pkg::net_msg_t enq_msg,

  output logic                 deq_val,
  input  logic                 deq_rdy,
  output router_pkg::net_msg_t deq_msg
);
  import router_pkg::*;

  net_msg_t                       entries [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
  logic [$clog2(QUEUE_DEPTH):0]   count;
  logic                           do_enq;
  logic                           do_deq;

  // full blocks enqueue even when the head leaves this cycle
  assign enq_rdy = (count != QUEUE_DEPTH);
  assign deq_val = (count != 0);
  assign deq_msg = entries[rd_ptr];

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  always_ff @(posedge clk) begin
    if (do_enq) begin
      entries[wr_ptr] <= enq_msg;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_deq) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== verilog/ring_input_port.sv ====
//----------------------------------------
// ring input with one queue per security domain
// messages for this node go to the terminal, the rest pass straight on
//----------------------------------------

module ring_input_port #(
  parameter router_pkg::node_id_t router_id    = '0,
  parameter router_pkg::port_e    forward_port = router_pkg::PORT_EAST
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cur_sd,

  input  logic                 in_val,
  output logic                 in_rdy,
  input  router_pkg::net_msg_t in_msg,

  switch_chan_if.input_side    chan
);
  import router_pkg::*;

  logic [1:0] enq_val;
  logic [1:0] enq_rdy;
  logic [1:0] deq_val;
  logic [1:0] deq_rdy;
  net_msg_t   deq_msg [2];

  //----------------------------------------
  // per-domain queues
  //----------------------------------------

  for (genvar d = 0; d < 2; d++) begin : g_domain
    // only the current domain enqueues or pops
    assign enq_val[d] = in_val && (cur_sd == 1'(d));
    assign deq_rdy[d] = chan.grant && (cur_sd == 1'(d));

    net_queue queue (
      .clk     (clk),
      .reset   (reset),
      .enq_val (enq_val[d]),
      .enq_rdy (enq_rdy[d]),
      .enq_msg (in_msg),
      .deq_val (deq_val[d]),
      .deq_rdy (deq_rdy[d]),
      .deq_msg (deq_msg[d])
    );
  end

  assign in_rdy   = enq_rdy[cur_sd];
  assign chan.val = deq_val[cur_sd];
  assign chan.msg = deq_msg[cur_sd];

  //----------------------------------------
  // route computation
  //----------------------------------------

  always_comb begin
    chan.reqs = '0;
    if (chan.val) begin
      if (msg_dest(chan.msg) == router_id) begin
        chan.reqs[PORT_TERM] = 1'b1;
      end else begin
        // no turning on the ring, keep going the same way
        chan.reqs[forward_port] = 1'b1;
      end
    end
  end

endmodule

// ==== verilog/terminal_input_port.sv ====
//----------------------------------------
// terminal input, offered only while its domain is the active one
//----------------------------------------

module terminal_input_port #(
  parameter router_pkg::node_id_t router_id = '0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cur_sd,
  input  logic                 in1_sd,

  input  logic                 in_val,
  output logic                 in_rdy,
  input  router_pkg::net_msg_t in_msg,

  switch_chan_if.input_side    chan
);
  import router_pkg::*;

  logic     active;
  logic     deq_val;
  net_msg_t deq_msg;
  node_id_t east_dist;

  // enqueue always open, the gate sits on the dequeue side
  net_queue queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (in_val),
    .enq_rdy (in_rdy),
    .enq_msg (in_msg),
    .deq_val (deq_val),
    .deq_rdy (active && chan.grant),
    .deq_msg (deq_msg)
  );

  assign active   = (in1_sd == cur_sd);
  assign chan.val = active && deq_val;
  assign chan.msg = active ? deq_msg : '0;

  // hops going east, mod ring size by wrap of the id width
  assign east_dist = msg_dest(deq_msg) - router_id;

  always_comb begin
    chan.reqs = '0;
    if (chan.val) begin
      if (east_dist == '0) begin
        chan.reqs[PORT_TERM] = 1'b1;
      end else if (east_dist <= node_id_t'(NUM_ROUTERS / 2)) begin
        chan.reqs[PORT_EAST] = 1'b1;
      end else begin
        chan.reqs[PORT_WEST] = 1'b1;
      end
    end
  end

endmodule

// ==== verilog/rr_arbiter.sv ====
//----------------------------------------
// round-robin arbiter for one router output
//----------------------------------------

module rr_arbiter (
  input  logic                   clk,
  input  logic                   reset,
  input  router_pkg::port_mask_t reqs,
  input  logic                   out_rdy,
  output router_pkg::port_mask_t grants,
  output logic                   out_val,
  output router_pkg::port_sel_t  sel
);
  import router_pkg::*;

  port_sel_t ptr;
  port_sel_t winner;
  logic      found;

  // first requester at or after the pointer
  always_comb begin
    int idx;
    found  = 1'b0;
    winner = ptr;
    for (int i = 0; i < NUM_PORTS; i++) begin
      idx = (int'(ptr) + i) % NUM_PORTS;
      if (!found && reqs[idx]) begin
        found  = 1'b1;
        winner = port_sel_t'(idx);
      end
    end
  end

  always_comb begin
    grants = '0;
    if (found && out_rdy) begin
      grants[winner] = 1'b1;
    end
  end

  assign out_val = |reqs;
  assign sel     = winner;

  // a stalled winner keeps the pointer so its message stays on the output
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (out_val) begin
      if (out_rdy) begin
        ptr <= (winner == port_sel_t'(NUM_PORTS - 1)) ? '0 : winner + 1'b1;
      end else begin
        ptr <= winner;
      end
    end
  end

endmodule

// ==== verilog/switch_allocator.sv ====
//----------------------------------------
// output arbiters and message crossbar
// inputs and outputs are indexed west, terminal, east
//----------------------------------------

module switch_allocator (
  input  logic                 clk,
  input  logic                 reset,

  switch_chan_if.alloc_side    west,
  switch_chan_if.alloc_side    term,
  switch_chan_if.alloc_side    east,

  output logic [2:0]           out_val,
  input  logic [2:0]           out_rdy,
  output router_pkg::net_msg_t out0_msg,
  output router_pkg::net_msg_t out1_msg,
  output router_pkg::net_msg_t out2_msg
);
  import router_pkg::*;

  port_mask_t in_reqs    [NUM_PORTS];
  net_msg_t   in_msg     [NUM_PORTS];
  port_mask_t out_reqs   [NUM_PORTS];
  port_mask_t out_grants [NUM_PORTS];
  port_sel_t  out_sel    [NUM_PORTS];
  net_msg_t   xbar_msg   [NUM_PORTS];

  // requests only count with a valid head
  assign in_reqs[0] = west.val ? west.reqs : '0;
  assign in_reqs[1] = term.val ? term.reqs : '0;
  assign in_reqs[2] = east.val ? east.reqs : '0;

  assign in_msg[0] = west.msg;
  assign in_msg[1] = term.msg;
  assign in_msg[2] = east.msg;

  //----------------------------------------
  // one arbiter per output
  //----------------------------------------

  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
    // transpose, bit i is input i asking for output o
    assign out_reqs[o] = {in_reqs[2][o], in_reqs[1][o], in_reqs[0][o]};

    rr_arbiter arb (
      .clk     (clk),
      .reset   (reset),
      .reqs    (out_reqs[o]),
      .out_rdy (out_rdy[o]),
      .grants  (out_grants[o]),
      .out_val (out_val[o]),
      .sel     (out_sel[o])
    );

    always_comb begin
      case (out_sel[o])
        2'd0:    xbar_msg[o] = in_msg[0];
        2'd1:    xbar_msg[o] = in_msg[1];
        2'd2:    xbar_msg[o] = in_msg[2];
        default: xbar_msg[o] = '0;
      endcase
    end
  end

  // each input holds at most one request, so one grant at most
  assign west.grant = out_grants[0][0] | out_grants[1][0] | out_grants[2][0];
  assign term.grant = out_grants[0][1] | out_grants[1][1] | out_grants[2][1];
  assign east.grant = out_grants[0][2] | out_grants[1][2] | out_grants[2][2];

  assign out0_msg = xbar_msg[0];
  assign out1_msg = xbar_msg[1];
  assign out2_msg = xbar_msg[2];

endmodule

// ==== verilog/router_top.sv ====
//----------------------------------------
// ring router with west, terminal and east ports and two domains
// cur_sd picks the active domain, in1_sd tags the terminal traffic
//----------------------------------------

module router_top #(
  parameter router_pkg::node_id_t router_id = 3'd2
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cur_sd,
  input  logic                 in1_sd,

  input  logic                 in0_val,
  output logic                 in0_rdy,
  input  router_pkg::net_msg_t in0_msg,

  input  logic                 in1_val,
  output logic                 in1_rdy,
  input  router_pkg::net_msg_t in1_msg,

  input  logic                 in2_val,
  output logic                 in2_rdy,
  input  router_pkg::net_msg_t in2_msg,

  output logic                 out0_val,
  input  logic                 out0_rdy,
  output router_pkg::net_msg_t out0_msg,

  output logic                 out1_val,
  input  logic                 out1_rdy,
  output router_pkg::net_msg_t out1_msg,

  output logic                 out2_val,
  input  logic                 out2_rdy,
  output router_pkg::net_msg_t out2_msg
);
  import router_pkg::*;

  switch_chan_if west_chan ();
  switch_chan_if term_chan ();
  switch_chan_if east_chan ();

  //----------------------------------------
  // input ports
  //----------------------------------------

  // west traffic heads east unless it is for us
  ring_input_port #(
    .router_id    (router_id),
    .forward_port (PORT_EAST)
  ) west_port (
    .clk    (clk),
    .reset  (reset),
    .cur_sd (cur_sd),
    .in_val (in0_val),
    .in_rdy (in0_rdy),
    .in_msg (in0_msg),
    .chan   (west_chan.input_side)
  );

  terminal_input_port #(
    .router_id (router_id)
  ) term_port (
    .clk    (clk),
    .reset  (reset),
    .cur_sd (cur_sd),
    .in1_sd (in1_sd),
    .in_val (in1_val),
    .in_rdy (in1_rdy),
    .in_msg (in1_msg),
    .chan   (term_chan.input_side)
  );

  ring_input_port #(
    .router_id    (router_id),
    .forward_port (PORT_WEST)
  ) east_port (
    .clk    (clk),
    .reset  (reset),
    .cur_sd (cur_sd),
    .in_val (in2_val),
    .in_rdy (in2_rdy),
    .in_msg (in2_msg),
    .chan   (east_chan.input_side)
  );

  //----------------------------------------
  // arbitration and crossbar
  //----------------------------------------

  switch_allocator alloc (
    .clk      (clk),
    .reset    (reset),
    .west     (west_chan.alloc_side),
    .term     (term_chan.alloc_side),
    .east     (east_chan.alloc_side),
    .out_val  ({out2_val, out1_val, out0_val}),
    .out_rdy  ({out2_rdy, out1_rdy, out0_rdy}),
    .out0_msg (out0_msg),
    .out1_msg (out1_msg),
    .out2_msg (out2_msg)
  );

endmodule

// ==== testbench/router_props.sv ====
//----------------------------------------
// concurrent checks on the router outputs
// bound into router_top, failures are counted for the testbench
//----------------------------------------

module router_props (
  input logic                       clk,
  input logic                       reset,
  input logic                       cur_sd,
  input logic                       in1_sd,
  input logic                 [2:0] out_val,
  input logic                 [2:0] out_rdy,
  input router_pkg::net_msg_t [2:0] out_msg
);
  timeunit 1ns;
  timeprecision 1ps;

  // read by the testbench at the end of the run
  int assert_failures = 0;

  // nothing valid leaves right after reset
  reset_clears_out: assert property (@(posedge clk) reset |=> out_val == 3'b000)
    else begin
      assert_failures++;
      $error("output val high in the cycle after reset");
    end

  for (genvar o = 0; o < 3; o++) begin : g_out
    // a stalled output only moves when the active domain changes
    val_held: assert property (@(posedge clk) disable iff (reset)
      out_val[o] && !out_rdy[o] |=> out_val[o] || !$stable(cur_sd) || !$stable(in1_sd))
      else begin
        assert_failures++;
        $error("out%0d_val fell without a transfer", o);
      end

    msg_held: assert property (@(posedge clk) disable iff (reset)
      out_val[o] && !out_rdy[o] |=>
        $stable(out_msg[o]) || !out_val[o] || !$stable(cur_sd) || !$stable(in1_sd))
      else begin
        assert_failures++;
        $error("out%0d_msg changed while stalled", o);
      end
  end

endmodule

bind router_top router_props props_inst (
  .clk     (clk),
  .reset   (reset),
  .cur_sd  (cur_sd),
  .in1_sd  (in1_sd),
  .out_val ({out2_val, out1_val, out0_val}),
  .out_rdy ({out2_rdy, out1_rdy, out0_rdy}),
  .out_msg ({out2_msg, out1_msg, out0_msg})
);

// ==== testbench/router_tb.sv ====
//----------------------------------------
// directed testbench for the ring router at node 2
// top module for simulation, built from project.f
//----------------------------------------

module router_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import router_pkg::*;

  localparam int       WAIT_LIMIT = 100;
  localparam node_id_t ROUTER_ID  = 3'd2;

  logic     clk;
  logic     reset;
  logic     cur_sd;
  logic     in1_sd;
  logic     in0_val, in1_val, in2_val;
  logic     in0_rdy, in1_rdy, in2_rdy;
  net_msg_t in0_msg, in1_msg, in2_msg;
  logic     out0_val, out1_val, out2_val;
  logic     out0_rdy, out1_rdy, out2_rdy;
  net_msg_t out0_msg, out1_msg, out2_msg;

  router_top #(.router_id(ROUTER_ID)) router_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //----------------------------------------
  // message helpers
  //----------------------------------------

  function automatic net_msg_t make_msg(node_id_t dest, node_id_t src, opaque_t tag,
                                        payload_t payload);
    return {dest, src, tag, payload};
  endfunction

  function automatic node_id_t src_of(net_msg_t msg);
    return msg[PAYLOAD_NBITS+OPAQUE_NBITS +: SRCDEST_NBITS];
  endfunction

  // shorter way round from node 2, the halfway tie goes east
  function automatic int term_out_port(node_id_t dest);
    case (dest)
      3'd2:                   return 1;
      3'd3, 3'd4, 3'd5, 3'd6: return 2;
      default:                return 0;
    endcase
  endfunction

  //----------------------------------------
  // failure reporting and compares
  //----------------------------------------

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic report_timeout(string what);
    $display("timeout after %0d cycles: %s", WAIT_LIMIT, what);
    abort_run();
  endtask

  task automatic check_msg(net_msg_t got, net_msg_t exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s: got %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  //----------------------------------------
  // port access
  //----------------------------------------

  task automatic drive_in(int port, logic val, net_msg_t msg);
    case (port)
      0: begin
        in0_val = val;
        in0_msg = msg;
      end
      1: begin
        in1_val = val;
        in1_msg = msg;
      end
      default: begin
        in2_val = val;
        in2_msg = msg;
      end
    endcase
  endtask

  task automatic set_out_rdy(int port, logic rdy);
    case (port)
      0:       out0_rdy = rdy;
      1:       out1_rdy = rdy;
      default: out2_rdy = rdy;
    endcase
  endtask

  function automatic logic in_rdy_at(int port);
    return (port == 0) ? in0_rdy : (port == 1) ? in1_rdy : in2_rdy;
  endfunction

  function automatic logic out_val_at(int port);
    return (port == 0) ? out0_val : (port == 1) ? out1_val : out2_val;
  endfunction

  function automatic net_msg_t out_msg_at(int port);
    return (port == 0) ? out0_msg : (port == 1) ? out1_msg : out2_msg;
  endfunction

  task automatic to_drive_point();
    @(posedge clk);
    #1;
  endtask

  // holds val until the input takes the message
  task automatic send(int port, net_msg_t msg);
    int waited;
    waited = 0;
    drive_in(port, 1'b1, msg);
    @(negedge clk);
    while (!in_rdy_at(port)) begin
      if (waited == WAIT_LIMIT) begin
        report_timeout($sformatf("input %0d never accepted a message", port));
      end
      waited++;
      @(negedge clk);
    end
    to_drive_point();
    drive_in(port, 1'b0, '0);
  endtask

  task automatic wait_out_val(int port, string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!out_val_at(port)) begin
      if (waited == WAIT_LIMIT) begin
        report_timeout(what);
      end
      waited++;
      @(negedge clk);
    end
  endtask

  // takes one message from an output, rdy high only while waiting
  task automatic receive(int port, output net_msg_t msg);
    set_out_rdy(port, 1'b1);
    wait_out_val(port, $sformatf("no message on output %0d", port));
    msg = out_msg_at(port);
    to_drive_point();
    set_out_rdy(port, 1'b0);
  endtask

  //----------------------------------------
  // directed tests
  //----------------------------------------

  task automatic terminal_routing();
    net_msg_t msg;
    net_msg_t got;
    cur_sd = 1'b0;
    in1_sd = 1'b0;
    for (int d = 0; d < NUM_ROUTERS; d++) begin
      msg = make_msg(node_id_t'(d), ROUTER_ID, opaque_t'(d), $urandom);
      send(1, msg);
      receive(term_out_port(node_id_t'(d)), got);
      check_msg(got, msg, $sformatf("terminal message for node %0d", d));
    end
  endtask

  task automatic pass_through();
    net_msg_t msg;
    net_msg_t got;
    msg = make_msg(3'd5, 3'd1, 3'd0, $urandom);
    send(0, msg);
    receive(2, got);
    check_msg(got, msg, "west input heading east");
    msg = make_msg(ROUTER_ID, 3'd1, 3'd1, $urandom);
    send(0, msg);
    receive(1, got);
    check_msg(got, msg, "west input for this node");
    msg = make_msg(3'd5, 3'd3, 3'd2, $urandom);
    send(2, msg);
    receive(0, got);
    check_msg(got, msg, "east input heading west");
  endtask

  task automatic domain_isolation();
    net_msg_t msg_a;
    net_msg_t msg_b;
    net_msg_t got;
    msg_a = make_msg(3'd5, 3'd1, 3'd3, $urandom);
    msg_b = make_msg(3'd5, 3'd1, 3'd4, $urandom);
    cur_sd = 1'b0;
    send(0, msg_a);
    wait_out_val(2, "domain 0 message never reached out2");
    to_drive_point();
    cur_sd = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check_bit(out2_val, 1'b0, "out2_val while domain 1 is active");
    end
    to_drive_point();
    send(0, msg_b);
    receive(2, got);
    check_msg(got, msg_b, "domain 1 message");
    cur_sd = 1'b0;
    receive(2, got);
    check_msg(got, msg_a, "domain 0 message after switching back");
  endtask

  task automatic terminal_gating();
    net_msg_t msg;
    net_msg_t got;
    cur_sd = 1'b0;
    in1_sd = 1'b1;
    msg = make_msg(3'd5, ROUTER_ID, 3'd5, $urandom);
    send(1, msg);
    repeat (20) begin
      @(negedge clk);
      check_bit(out0_val | out1_val | out2_val, 1'b0, "output val with terminal gated");
    end
    to_drive_point();
    in1_sd = 1'b0;
    receive(2, got);
    check_msg(got, msg, "terminal message after release");
  endtask

  task automatic backpressure_order();
    net_msg_t sent [QUEUE_DEPTH];
    net_msg_t got;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      sent[i] = make_msg(3'd5, 3'd1, opaque_t'(i), $urandom);
      send(0, sent[i]);
    end
    @(negedge clk);
    check_bit(in0_rdy, 1'b0, "in0_rdy with a full queue");
    to_drive_point();
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      receive(2, got);
      check_msg(got, sent[i], $sformatf("drained message %0d", i));
    end
  endtask

  // west and terminal both stream east, sources must take turns
  task automatic output_fairness();
    net_msg_t west_msgs [4];
    net_msg_t term_msgs [4];
    for (int i = 0; i < 4; i++) begin
      west_msgs[i] = make_msg(3'd5, 3'd1, opaque_t'(i), $urandom);
      term_msgs[i] = make_msg(3'd5, ROUTER_ID, opaque_t'(i), $urandom);
    end
    fork
      for (int i = 0; i < 4; i++) begin
        send(0, west_msgs[i]);
      end
      for (int i = 0; i < 4; i++) begin
        send(1, term_msgs[i]);
      end
      begin
        net_msg_t got;
        node_id_t last_src;
        int       west_idx;
        int       term_idx;
        west_idx = 0;
        term_idx = 0;
        last_src = '0;
        for (int i = 0; i < 8; i++) begin
          receive(2, got);
          if (src_of(got) == 3'd1) begin
            check_msg(got, west_msgs[west_idx], "west stream on out2");
            west_idx++;
          end else begin
            check_msg(got, term_msgs[term_idx], "terminal stream on out2");
            term_idx++;
          end
          if (i > 0) begin
            check_bit(src_of(got) != last_src, 1'b1, "out2 source alternation");
          end
          last_src = src_of(got);
        end
      end
    join
  endtask

  //----------------------------------------
  // main sequence
  //----------------------------------------

  initial begin
    void'($urandom(32'hffc4));
    reset  = 1'b1;
    cur_sd = 1'b0;
    in1_sd = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      drive_in(p, 1'b0, '0);
      set_out_rdy(p, 1'b0);
    end
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle state straight after reset
    @(negedge clk);
    check_bit(out0_val | out1_val | out2_val, 1'b0, "output val after reset");
    check_bit(in0_rdy & in1_rdy & in2_rdy, 1'b1, "input rdy after reset");
    to_drive_point();

    terminal_routing();
    pass_through();
    domain_isolation();
    terminal_gating();
    backpressure_order();
    output_fairness();

    if (router_top_inst.props_inst.assert_failures == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("%0d property checks failed during the run",
               router_top_inst.props_inst.assert_failures);
      abort_run();
    end
  end

endmodule

// ==== project.f ====
verilog/router_pkg.sv
verilog/switch_chan_if.sv
verilog/net_queue.sv
verilog/ring_input_port.sv
verilog/terminal_input_port.sv
verilog/rr_arbiter.sv
verilog/switch_allocator.sv
verilog/router_top.sv
testbench/router_props.sv
testbench/router_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= router_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
